/* hw/switch_pkg.sv */
`default_nettype none

package switch_pkg;

    localparam int N_PORTS    = 4;
    localparam int N_PRIOS    = 4;    // 3 is the highest
    localparam int WORD_W     = 16;
    localparam int SLOT_WORDS = 16;   // also the longest packet
    localparam int OFF_W      = $clog2(SLOT_WORDS);
    localparam int MAX_SLOT_W = 4;

    typedef logic [1:0] port_t;
    typedef logic [1:0] prio_t;
    typedef logic [3:0] len_t;        // 0 stands for 16 words

    // first word of every packet
    typedef struct packed {
        port_t      dest;
        prio_t      prio;
        len_t       len;
        logic [7:0] tag;              // carried through, never looked at
    } pkt_hdr_t;

    // a stored word is either payload or a header
    typedef union packed {
        logic [WORD_W-1:0] raw;
        pkt_hdr_t          hdr;
    } pkt_word_u;

    typedef struct packed {
        logic                  valid;
        port_t                 dest;
        prio_t                 prio;
        logic [MAX_SLOT_W-1:0] slot;
    } enq_req_t;

endpackage

`default_nettype wire

/* hw/port_writer.sv */
`default_nettype none
`timescale 1ns/1ps

module port_writer import switch_pkg::*; #(
    parameter int N_SLOTS = 8,
    localparam int SLOT_W = $clog2(N_SLOTS)
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wr_sop,
    input  logic              wr_eop,
    input  logic              wr_vld,
    input  pkt_word_u         wr_data,
    input  logic              grant,
    input  logic [SLOT_W-1:0] grant_slot,
    output logic              need_slot,
    output logic              mem_we,
    output logic [SLOT_W-1:0] mem_slot,
    output logic [OFF_W-1:0]  mem_off,
    output pkt_word_u         mem_word,
    output enq_req_t          req,
    input  logic              accept,
    output logic              pause
);

    logic              has_slot;    // reservation for the next packet
    logic [SLOT_W-1:0] cur_slot;
    logic [OFF_W-1:0]  off;         // where the next word goes
    port_t             dest_q;
    prio_t             prio_q;
    logic              req_valid;
    logic [SLOT_W-1:0] req_slot;

    assign need_slot = !has_slot;
    assign pause     = !has_slot || req_valid;
    assign mem_we    = wr_vld;
    assign mem_slot  = cur_slot;
    assign mem_off   = wr_sop ? '0 : off;    // header always lands at offset 0
    assign mem_word  = wr_data;

    // dest and prio stay put while the request waits, since pause blocks the next sop
    always_comb begin
        req.valid = req_valid;
        req.dest  = dest_q;
        req.prio  = prio_q;
        req.slot  = MAX_SLOT_W'(req_slot);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            has_slot  <= 1'b0;
            req_valid <= 1'b0;
        end else begin
            if (grant) begin
                has_slot <= 1'b1;
            end else if (wr_vld && wr_eop) begin
                has_slot <= 1'b0;    // slot now belongs to the packet
            end
            if (wr_vld && wr_eop) begin
                req_valid <= 1'b1;
            end else if (accept) begin
                req_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            cur_slot <= grant_slot;
        end
        if (wr_vld) begin
            off <= mem_off + 1'b1;
        end
        if (wr_vld && wr_sop) begin
            dest_q <= wr_data.hdr.dest;
            prio_q <= wr_data.hdr.prio;
        end
        if (wr_vld && wr_eop) begin
            req_slot <= cur_slot;
        end
    end

endmodule

`default_nettype wire

/* hw/slot_pool.sv */
`default_nettype none
`timescale 1ns/1ps

module slot_pool import switch_pkg::*; #(
    parameter int N_SLOTS = 8,
    localparam int SLOT_W = $clog2(N_SLOTS)
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [N_PORTS-1:0]              need_slot,
    output logic [N_PORTS-1:0]              grant,
    output logic [N_PORTS-1:0][SLOT_W-1:0]  grant_slot,
    input  logic [N_PORTS-1:0]              mem_we,
    input  logic [N_PORTS-1:0][SLOT_W-1:0]  mem_slot,
    input  logic [N_PORTS-1:0][OFF_W-1:0]   mem_off,
    input  pkt_word_u [N_PORTS-1:0]         mem_word,
    input  logic [N_PORTS-1:0][SLOT_W-1:0]  rd_slot,
    input  logic [N_PORTS-1:0][OFF_W-1:0]   rd_off,
    output pkt_word_u [N_PORTS-1:0]         rd_word,
    input  logic [N_PORTS-1:0]              free_en,
    input  logic [N_PORTS-1:0][SLOT_W-1:0]  free_slot,
    output logic                            full
);

    pkt_word_u          mem [N_SLOTS][SLOT_WORDS];
    logic [N_SLOTS-1:0] free_map;    // 1 = slot unused
    logic [N_SLOTS-1:0] res_map;     // slots held by idle writers
    logic               any_free;
    logic [SLOT_W-1:0]  low_free;

    always_comb begin
        any_free = 1'b0;
        low_free = '0;
        for (int s = N_SLOTS - 1; s >= 0; s--) begin
            if (free_map[s]) begin
                any_free = 1'b1;
                low_free = SLOT_W'(s);
            end
        end
    end

    // at most one grant per cycle, lowest writer first
    always_comb begin
        grant = '0;
        for (int p = N_PORTS - 1; p >= 0; p--) begin
            if (need_slot[p] && any_free) begin
                grant    = '0;
                grant[p] = 1'b1;
            end
        end
        grant_slot = {N_PORTS{low_free}};
    end

    always_comb begin
        res_map = '0;
        for (int p = 0; p < N_PORTS; p++) begin
            if (!need_slot[p]) begin
                res_map[mem_slot[p]] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            free_map <= '1;
            full     <= 1'b0;
        end else begin
            for (int p = 0; p < N_PORTS; p++) begin
                if (free_en[p]) begin
                    free_map[free_slot[p]] <= 1'b1;
                end
            end
            if (|grant) begin
                free_map[low_free] <= 1'b0;
            end
            full <= !(|free_map) && !(|res_map);
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < N_PORTS; p++) begin
            if (mem_we[p]) begin
                mem[mem_slot[p]][mem_off[p]] <= mem_word[p];
            end
        end
    end

    always_comb begin
        for (int p = 0; p < N_PORTS; p++) begin
            rd_word[p] = mem[rd_slot[p]][rd_off[p]];    // async read
        end
    end

endmodule

`default_nettype wire

/* hw/enqueue_arbiter.sv */
`default_nettype none
`timescale 1ns/1ps

module enqueue_arbiter import switch_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  enq_req_t [N_PORTS-1:0]  reqs,
    output logic [N_PORTS-1:0]      accept,
    output enq_req_t                push
);

    // lowest valid port wins, the writer drops its request after the accept
    always_comb begin
        accept = '0;
        push   = '0;
        for (int p = N_PORTS - 1; p >= 0; p--) begin
            if (reqs[p].valid) begin
                accept    = '0;
                accept[p] = 1'b1;
                push      = reqs[p];
            end
        end
    end

endmodule

`default_nettype wire

/* hw/output_queues.sv */
`default_nettype none
`timescale 1ns/1ps

module output_queues import switch_pkg::*; #(
    parameter int N_SLOTS = 8,
    localparam int SLOT_W = $clog2(N_SLOTS)
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  enq_req_t                push,
    input  logic [N_PORTS-1:0]      pop,
    output logic [N_PORTS-1:0]      nonempty,
    output enq_req_t [N_PORTS-1:0]  head
);

    // only the slot is stored, dest and prio follow from the queue
    logic [SLOT_W-1:0] slots  [N_PORTS][N_PRIOS][N_SLOTS];
    logic [SLOT_W-1:0] rd_ptr [N_PORTS][N_PRIOS];
    logic [SLOT_W-1:0] wr_ptr [N_PORTS][N_PRIOS];
    logic [SLOT_W:0]   count  [N_PORTS][N_PRIOS];
    prio_t             sel    [N_PORTS];
    logic              push_hit [N_PORTS][N_PRIOS];
    logic              pop_hit  [N_PORTS][N_PRIOS];

    function automatic logic [SLOT_W-1:0] next_ptr(input logic [SLOT_W-1:0] ptr);
        return (ptr == SLOT_W'(N_SLOTS - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_comb begin
        for (int p = 0; p < N_PORTS; p++) begin
            sel[p]      = '0;
            nonempty[p] = 1'b0;
            for (int pr = 0; pr < N_PRIOS; pr++) begin
                if (count[p][pr] != '0) begin
                    sel[p]      = prio_t'(pr);    // last hit is the highest
                    nonempty[p] = 1'b1;
                end
            end
            head[p].valid = nonempty[p];
            head[p].dest  = port_t'(p);
            head[p].prio  = sel[p];
            head[p].slot  = MAX_SLOT_W'(slots[p][sel[p]][rd_ptr[p][sel[p]]]);
            for (int pr = 0; pr < N_PRIOS; pr++) begin
                push_hit[p][pr] = push.valid && push.dest == port_t'(p)
                                  && push.prio == prio_t'(pr);
                pop_hit[p][pr]  = pop[p] && sel[p] == prio_t'(pr);
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < N_PORTS; p++) begin
            for (int pr = 0; pr < N_PRIOS; pr++) begin
                if (!rst_n) begin
                    rd_ptr[p][pr] <= '0;
                    wr_ptr[p][pr] <= '0;
                    count[p][pr]  <= '0;
                end else begin
                    if (push_hit[p][pr]) begin
                        wr_ptr[p][pr] <= next_ptr(wr_ptr[p][pr]);
                    end
                    if (pop_hit[p][pr]) begin
                        rd_ptr[p][pr] <= next_ptr(rd_ptr[p][pr]);
                    end
                    case ({push_hit[p][pr], pop_hit[p][pr]})
                        2'b10:   count[p][pr] <= count[p][pr] + 1'b1;
                        2'b01:   count[p][pr] <= count[p][pr] - 1'b1;
                        default: count[p][pr] <= count[p][pr];
                    endcase
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push.valid) begin
            slots[push.dest][push.prio][wr_ptr[push.dest][push.prio]] <= push.slot[SLOT_W-1:0];
        end
    end

endmodule

`default_nettype wire

/* hw/port_reader.sv */
`default_nettype none
`timescale 1ns/1ps

module port_reader import switch_pkg::*; #(
    parameter int N_SLOTS = 8,
    localparam int SLOT_W = $clog2(N_SLOTS)
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ready,
    input  logic              nonempty,
    input  enq_req_t          head,
    output logic              pop,
    output logic [SLOT_W-1:0] rd_slot,
    output logic [OFF_W-1:0]  rd_off,
    input  pkt_word_u         rd_word,
    output logic              free_en,
    output logic [SLOT_W-1:0] free_slot,
    output logic              rd_sop,
    output logic              rd_eop,
    output logic              rd_vld,
    output logic [WORD_W-1:0] rd_data
);

    logic              busy;
    logic [SLOT_W-1:0] slot_q;
    logic [OFF_W-1:0]  off;
    len_t              left_q;      // words still to come after this one
    len_t              left_now;

    assign pop       = !busy && ready && nonempty;
    assign rd_slot   = slot_q;
    assign rd_off    = off;
    assign free_slot = slot_q;      // still the old slot during the free cycle

    // header gives the length, len 0 wraps to 15 more words
    assign left_now = (off == '0) ? rd_word.hdr.len - 1'b1 : left_q;

    assign rd_vld  = busy;
    assign rd_sop  = busy && off == '0;
    assign rd_eop  = busy && left_now == '0;
    assign rd_data = busy ? rd_word.raw : '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            free_en <= 1'b0;
        end else begin
            free_en <= rd_eop;      // slot goes back one cycle after eop
            if (pop) begin
                busy <= 1'b1;
            end else if (rd_eop) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            slot_q <= head.slot[SLOT_W-1:0];
            off    <= '0;
        end else if (busy) begin
            off    <= off + 1'b1;
            left_q <= left_now - 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hw/packet_switch.sv */
`default_nettype none
`timescale 1ns/1ps

module packet_switch import switch_pkg::*; #(
    parameter int N_SLOTS = 8
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [N_PORTS-1:0]              wr_sop,
    input  logic [N_PORTS-1:0]              wr_eop,
    input  logic [N_PORTS-1:0]              wr_vld,
    input  logic [N_PORTS-1:0][WORD_W-1:0]  wr_data,
    output logic [N_PORTS-1:0]              pause,
    output logic                            full,
    input  logic [N_PORTS-1:0]              ready,
    output logic [N_PORTS-1:0]              rd_sop,
    output logic [N_PORTS-1:0]              rd_eop,
    output logic [N_PORTS-1:0]              rd_vld,
    output logic [N_PORTS-1:0][WORD_W-1:0]  rd_data
);

    localparam int SLOT_W = $clog2(N_SLOTS);

    // writer side
    logic [N_PORTS-1:0]             need_slot;
    logic [N_PORTS-1:0]             grant;
    logic [N_PORTS-1:0][SLOT_W-1:0] grant_slot;
    logic [N_PORTS-1:0]             mem_we;
    logic [N_PORTS-1:0][SLOT_W-1:0] mem_slot;
    logic [N_PORTS-1:0][OFF_W-1:0]  mem_off;
    pkt_word_u [N_PORTS-1:0]        mem_word;
    enq_req_t [N_PORTS-1:0]         reqs;
    logic [N_PORTS-1:0]             accept;
    enq_req_t                       push;

    // reader side
    logic [N_PORTS-1:0]             pop;
    logic [N_PORTS-1:0]             nonempty;
    enq_req_t [N_PORTS-1:0]         head;
    logic [N_PORTS-1:0][SLOT_W-1:0] rd_slot;
    logic [N_PORTS-1:0][OFF_W-1:0]  rd_off;
    pkt_word_u [N_PORTS-1:0]        rd_word;
    logic [N_PORTS-1:0]             free_en;
    logic [N_PORTS-1:0][SLOT_W-1:0] free_slot;

    for (genvar p = 0; p < N_PORTS; p++) begin : g_port
        port_writer #(.N_SLOTS(N_SLOTS)) u_writer (
            .clk(clk), .rst_n(rst_n),
            .wr_sop(wr_sop[p]), .wr_eop(wr_eop[p]), .wr_vld(wr_vld[p]), .wr_data(wr_data[p]),
            .grant(grant[p]), .grant_slot(grant_slot[p]), .need_slot(need_slot[p]),
            .mem_we(mem_we[p]), .mem_slot(mem_slot[p]), .mem_off(mem_off[p]),
            .mem_word(mem_word[p]), .req(reqs[p]), .accept(accept[p]), .pause(pause[p])
        );

        port_reader #(.N_SLOTS(N_SLOTS)) u_reader (
            .clk(clk), .rst_n(rst_n),
            .ready(ready[p]), .nonempty(nonempty[p]), .head(head[p]), .pop(pop[p]),
            .rd_slot(rd_slot[p]), .rd_off(rd_off[p]), .rd_word(rd_word[p]),
            .free_en(free_en[p]), .free_slot(free_slot[p]),
            .rd_sop(rd_sop[p]), .rd_eop(rd_eop[p]), .rd_vld(rd_vld[p]), .rd_data(rd_data[p])
        );
    end

    slot_pool #(.N_SLOTS(N_SLOTS)) u_pool (
        .clk(clk), .rst_n(rst_n),
        .need_slot(need_slot), .grant(grant), .grant_slot(grant_slot),
        .mem_we(mem_we), .mem_slot(mem_slot), .mem_off(mem_off), .mem_word(mem_word),
        .rd_slot(rd_slot), .rd_off(rd_off), .rd_word(rd_word),
        .free_en(free_en), .free_slot(free_slot), .full(full)
    );

    enqueue_arbiter u_arbiter (
        .clk(clk), .rst_n(rst_n), .reqs(reqs), .accept(accept), .push(push)
    );

    output_queues #(.N_SLOTS(N_SLOTS)) u_queues (
        .clk(clk), .rst_n(rst_n), .push(push), .pop(pop), .nonempty(nonempty), .head(head)
    );

endmodule

`default_nettype wire

/* tests/clock_gen.sv */
`default_nettype none
`timescale 1ns/1ps

module clock_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;    // released just after an edge
    end

endmodule

`default_nettype wire

/* tests/switch_assertions.sv */
`default_nettype none
`timescale 1ns/1ps

module switch_assertions import switch_pkg::*; (
    input logic               clk,
    input logic               rst_n,
    input logic [N_PORTS-1:0] ready,
    input logic [N_PORTS-1:0] rd_sop,
    input logic [N_PORTS-1:0] rd_eop,
    input logic [N_PORTS-1:0] rd_vld,
    input logic [N_PORTS-1:0] wr_sop,
    input logic [N_PORTS-1:0] pause
);

    for (genvar p = 0; p < N_PORTS; p++) begin : g_chk
        a_strobe_vld: assert property (@(posedge clk) disable iff (!rst_n)
            (rd_sop[p] || rd_eop[p]) |-> rd_vld[p])
            else $error("rd_sop or rd_eop without rd_vld on port %0d", p);

        // the pop happens in the ready cycle, the header one cycle later
        a_sop_after_ready: assert property (@(posedge clk) disable iff (!rst_n)
            rd_sop[p] |-> $past(ready[p]))
            else $error("rd_sop on port %0d without ready in the cycle before", p);

        a_no_start_paused: assert property (@(posedge clk) disable iff (!rst_n)
            $rose(wr_sop[p]) |-> !pause[p])
            else $error("packet started on port %0d while pause was high", p);
    end

endmodule

`default_nettype wire

/* tests/tb_packet_switch.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_packet_switch import switch_pkg::*; ();

    logic                           clk;
    logic                           rst_n;
    logic [N_PORTS-1:0]             wr_sop;
    logic [N_PORTS-1:0]             wr_eop;
    logic [N_PORTS-1:0]             wr_vld;
    logic [N_PORTS-1:0][WORD_W-1:0] wr_data;
    logic [N_PORTS-1:0]             ready;
    logic [N_PORTS-1:0]             pause;
    logic                           full;
    logic [N_PORTS-1:0]             rd_sop;
    logic [N_PORTS-1:0]             rd_eop;
    logic [N_PORTS-1:0]             rd_vld;
    logic [N_PORTS-1:0][WORD_W-1:0] rd_data;

    string       test_name [8];
    logic [3:0]  test_mask [8];
    int          test_full [8];
    int          test_first [8];
    int          test_cnt [8];
    int          n_tests;
    int          n_pkts;
    logic [15:0] pkt_w [64][16];    // word 0 is the header
    int          pkt_port [64];
    int          pkt_len [64];
    int          pkt_done [64];     // cycle of the eop beat
    logic [15:0] got_w [4][16][16];
    int          got_len [4][16];
    int          got_n [4];
    int          cap_n [4];
    int          cycle;
    int          limit;
    int          senders_left;
    logic [3:0]  waiting;
    int unsigned seed;

    clock_gen #(.PERIOD(40), .RESET_CYCLES(5)) u_clk (.clk(clk), .rst_n(rst_n));

    packet_switch #(.N_SLOTS(8)) DUT (.*);

    bind packet_switch switch_assertions u_assertions (
        .clk(clk), .rst_n(rst_n), .ready(ready), .rd_sop(rd_sop), .rd_eop(rd_eop),
        .rd_vld(rd_vld), .wr_sop(wr_sop), .pause(pause)
    );

    function automatic int unsigned lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return (seed >> 16) & 32'h7fff;
    endfunction

    function automatic int len_of(logic [15:0] hdr);
        return (hdr[11:8] == 4'd0) ? 16 : int'(hdr[11:8]);
    endfunction

    function automatic int total_got();
        return got_n[0] + got_n[1] + got_n[2] + got_n[3];
    endfunction

    task automatic fail_now(string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_val(string tname, int exp, int act);
        assert (exp == act)
            else fail_now($sformatf("Fail %s expected %0h actual %0h", tname, exp, act));
    endtask

    always @(posedge clk) begin
        cycle++;
        if (limit > 0 && cycle > limit) begin
            fail_now($sformatf("timeout: no finish within %0d cycles", limit));
        end
    end

    // capture every output burst, sampled away from the edges
    always @(negedge clk) begin
        if (rst_n) begin
            for (int p = 0; p < N_PORTS; p++) begin
                if (rd_vld[p]) begin
                    assert (rd_sop[p] == (cap_n[p] == 0))
                        else fail_now($sformatf("rd_sop misplaced on output %0d", p));
                    got_w[p][got_n[p]][cap_n[p]] = rd_data[p];
                    cap_n[p]++;
                    if (rd_eop[p]) begin
                        got_len[p][got_n[p]] = cap_n[p];
                        got_n[p]++;
                        cap_n[p] = 0;
                    end
                end
            end
        end
    end

    task automatic read_stimulus();
        int          fd;
        int          r;
        int          port;
        int          mask;
        int          num;
        string       line;
        string       kind;
        string       name;
        logic [15:0] w [16];
        fd = $fopen("tests/switch_stimulus.txt", "r");
        if (fd == 0) fail_now("cannot open tests/switch_stimulus.txt");
        while (!$feof(fd)) begin
            r = $fgets(line, fd);
            if (r == 0) break;
            if (line.len() < 3 || line.getc(0) == 8'h23) continue;
            r = $sscanf(line, "%s", kind);
            if (kind == "P") begin
                r = $sscanf(line, "%s %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            kind, port, w[0], w[1], w[2], w[3], w[4], w[5], w[6], w[7],
                            w[8], w[9], w[10], w[11], w[12], w[13], w[14], w[15]);
                pkt_port[n_pkts] = port;
                pkt_len[n_pkts]  = len_of(w[0]);
                for (int i = 0; i < 16; i++) pkt_w[n_pkts][i] = w[i];
                n_pkts++;
                test_cnt[n_tests-1]++;
            end else begin
                r = $sscanf(line, "%s %s %h %d", kind, name, mask, num);
                test_name[n_tests]  = name;
                test_mask[n_tests]  = mask[3:0];
                test_full[n_tests]  = (kind == "T") ? num : 0;
                test_first[n_tests] = n_pkts;
                test_cnt[n_tests]   = 0;
                n_tests++;
                for (int k = 0; kind == "R" && k < num; k++) begin
                    pkt_port[n_pkts] = k % N_PORTS;    // inputs in turn, destinations random
                    pkt_w[n_pkts][0] = {2'(lcg_next() % 4), 2'(lcg_next() % 4),
                                        4'(lcg_next() % 16), 8'(lcg_next())};
                    pkt_len[n_pkts]  = len_of(pkt_w[n_pkts][0]);
                    for (int i = 1; i < 16; i++) pkt_w[n_pkts][i] = 16'(lcg_next());
                    n_pkts++;
                    test_cnt[n_tests-1]++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic send_port(input int p, input int t);
        for (int i = test_first[t]; i < test_first[t] + test_cnt[t]; i++) begin
            if (pkt_port[i] != p) continue;
            waiting[p] = 1'b1;
            @(posedge clk);
            #1;
            while (pause[p]) begin
                @(posedge clk);
                #1;
            end
            waiting[p] = 1'b0;
            for (int w = 0; w < pkt_len[i]; w++) begin
                wr_vld[p]  = 1'b1;
                wr_sop[p]  = (w == 0);
                wr_eop[p]  = (w == pkt_len[i] - 1);
                wr_data[p] = pkt_w[i][w];
                @(posedge clk);
                #1;
            end
            wr_vld[p] = 1'b0;
            wr_sop[p] = 1'b0;
            wr_eop[p] = 1'b0;
            pkt_done[i] = cycle;
        end
        senders_left--;
    endtask

    // strict priority while ready is held low, then arrival order
    function automatic int order_key(int i, int t, int p);
        int prio;
        prio = int'(pkt_w[i][0][13:12]);
        return (test_mask[t][p] ? 0 : (3 - prio)) * 100000 + pkt_done[i] * 4 + pkt_port[i];
    endfunction

    task automatic compare_outputs(int t);
        int exp [$];
        int tmp;
        for (int p = 0; p < N_PORTS; p++) begin
            exp.delete();
            for (int i = test_first[t]; i < test_first[t] + test_cnt[t]; i++) begin
                if (int'(pkt_w[i][0][15:14]) == p) exp.push_back(i);
            end
            for (int a = 0; a < exp.size(); a++) begin
                for (int b = a + 1; b < exp.size(); b++) begin
                    if (order_key(exp[b], t, p) < order_key(exp[a], t, p)) begin
                        tmp    = exp[a];
                        exp[a] = exp[b];
                        exp[b] = tmp;
                    end
                end
            end
            check_val(test_name[t], exp.size(), got_n[p]);
            for (int k = 0; k < exp.size(); k++) begin
                check_val(test_name[t], pkt_len[exp[k]], got_len[p][k]);
                for (int w = 0; w < pkt_len[exp[k]]; w++) begin
                    check_val(test_name[t], pkt_w[exp[k]][w], got_w[p][k][w]);
                end
            end
        end
    endtask

    task automatic run_test(int t);
        int saw_full;
        saw_full = 0;
        ready    = test_mask[t];
        for (int p = 0; p < N_PORTS; p++) begin
            got_n[p] = 0;
            cap_n[p] = 0;
        end
        senders_left = N_PORTS;
        for (int p = 0; p < N_PORTS; p++) begin
            fork
                automatic int q = p;
                send_port(q, t);
            join_none
        end
        while (senders_left > 0) begin
            @(posedge clk);
            #1;
            if (full) begin
                saw_full = 1;
                assert ((pause & waiting) != '0)
                    else fail_now("full is high but no blocked input shows pause");
                ready = '1;    // let the held packet through
            end
        end
        check_val(test_name[t], test_full[t], saw_full);
        // one request is accepted per cycle, so all are queued after N_PORTS cycles
        repeat (N_PORTS) @(posedge clk);
        #1;
        ready = '1;
        while (total_got() < test_cnt[t]) @(posedge clk);
        repeat (3) @(posedge clk);
        #1;
        assert (!full) else fail_now("full still high after all slots drained");
        compare_outputs(t);
    endtask

    initial begin
        wr_sop  = '0;
        wr_eop  = '0;
        wr_vld  = '0;
        wr_data = '0;
        ready   = '0;
        waiting = '0;
        cycle   = 0;
        limit   = 0;
        n_tests = 0;
        n_pkts  = 0;
        seed    = 64316;
        read_stimulus();
        limit = 40 * n_pkts + 200;
        wait (rst_n);
        for (int t = 0; t < n_tests; t++) begin
            run_test(t);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/switch_stimulus.txt */
# T name ready_mask(hex) expect_full | R name ready_mask(hex) random_packet_count
# P input_port header(hex) payload words(hex), header = dest:2 prio:2 len:4 tag:8
T single f 0
P 0 4302 1111 2222
P 1 8201 aaaa
P 2 c103
P 3 0405 0a0a 0b0b 0c0c
T prio e 0
P 1 0210 0001
P 2 3211 0002
P 3 1212 0003
P 0 3213 0004
P 1 2314 0005 0006
T fanin f 0
P 0 8220 00a0
P 1 8221 00a1
P 2 8222 00a2
P 3 8223 00a3
T fill 0 1
P 0 0230 0100
P 1 4231 0101
P 2 8232 0102
P 3 c233 0103
P 0 0234 0104
P 1 4235 0105
P 2 8236 0106
P 3 c237 0107
P 0 0238 0108
R random 0 6

/* all.f */
hw/switch_pkg.sv
hw/port_writer.sv
hw/slot_pool.sv
hw/enqueue_arbiter.sv
hw/output_queues.sv
hw/port_reader.sv
hw/packet_switch.sv
tests/clock_gen.sv
tests/switch_assertions.sv
tests/tb_packet_switch.sv

/* run.sh */
#!/bin/bash
# compile with Verilator and run, exit status follows the simulation
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal -f all.f \
        --top-module tb_packet_switch -o sim \
    && ./obj_dir/sim \
    || exit 1
